//--- rtl/trace_pkg.sv
// ================================================
// trace sniffer shared definitions
// widths, capture record layout and register map
// ================================================
`default_nettype none

package trace_pkg;

   parameter int TRACE_NIBBLE_W = 4;
   parameter int BYTE_W         = 8;
   parameter int WINDOW_BYTES   = 8;   // 64-bit history window
   parameter int TIME_W         = 16;
   parameter int CFG_ADDR_W     = 6;
   parameter int CFG_DATA_W     = 32;

   typedef enum logic [1:0] {
      KIND_RAW   = 2'd0,   // raw trace byte
      KIND_MATCH = 2'd1    // rule match bitmap
   } record_kind_t;

   typedef struct packed {
      record_kind_t        kind;
      logic [BYTE_W-1:0]   data;
      logic [TIME_W-1:0]   timestamp;
   } capture_record_t;

   // register map, rule n lives at REG_RULE_BASE + 4n
   parameter logic [CFG_ADDR_W-1:0] REG_CONTROL     = 6'd0;
   parameter logic [CFG_ADDR_W-1:0] REG_RULE_ENABLE = 6'd1;
   parameter logic [CFG_ADDR_W-1:0] REG_TRIG_DELAY  = 6'd2;
   parameter logic [CFG_ADDR_W-1:0] REG_TRIG_WIDTH  = 6'd3;
   parameter logic [CFG_ADDR_W-1:0] REG_RULE_BASE   = 6'd8;

endpackage

`default_nettype wire

//--- rtl/trace_cfg_if.sv
// ================================================
// match rule settings, registers to matcher
// ================================================
`timescale 1ns/1ps
`default_nettype none

interface trace_cfg_if #(
   parameter int MATCH_RULES = 4
);
   localparam int WIN_W = trace_pkg::WINDOW_BYTES * trace_pkg::BYTE_W;

   logic [WIN_W-1:0]       pattern [MATCH_RULES];
   logic [WIN_W-1:0]       mask    [MATCH_RULES];
   logic [MATCH_RULES-1:0] rule_enable;
   logic [MATCH_RULES-1:0] trig_enable;   // rule may fire the trigger

   modport regs    (output pattern, mask, rule_enable, trig_enable);
   modport matcher (input  pattern, mask, rule_enable, trig_enable);

endinterface

`default_nettype wire

//--- rtl/trace_regs.sv
// ================================================
// write-only configuration registers
// control bits, trigger timing and match rules
// ================================================
`timescale 1ns/1ps
`default_nettype none

module trace_regs #(
   parameter int MATCH_RULES = 4
) (
   input  logic                             trace_clk,
   input  logic                             reset,
   input  logic                             cfg_write,
   input  logic [trace_pkg::CFG_ADDR_W-1:0] cfg_addr,
   input  logic [trace_pkg::CFG_DATA_W-1:0] cfg_data,
   trace_cfg_if.regs                        cfg,
   output logic                             arm,
   output logic                             capture_raw,
   output logic [trace_pkg::CFG_DATA_W-1:0] trig_delay,
   output logic [trace_pkg::CFG_DATA_W-1:0] trig_width
);
   localparam int AW = trace_pkg::CFG_ADDR_W;
   localparam int DW = trace_pkg::CFG_DATA_W;

   logic [AW-1:0] rule_off;   // offset into the rule block
   logic          rule_sel;

   assign rule_off = cfg_addr - trace_pkg::REG_RULE_BASE;
   assign rule_sel = cfg_write && (cfg_addr >= trace_pkg::REG_RULE_BASE);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         arm             <= 1'b0;
         capture_raw     <= 1'b0;
         trig_delay      <= '0;
         trig_width      <= '0;
         cfg.rule_enable <= '0;
         cfg.trig_enable <= '0;
      end else if (cfg_write) begin
         case (cfg_addr)
            trace_pkg::REG_CONTROL: begin
               arm         <= cfg_data[0];
               capture_raw <= cfg_data[1];
            end
            trace_pkg::REG_RULE_ENABLE: begin
               cfg.rule_enable <= cfg_data[MATCH_RULES-1:0];
               cfg.trig_enable <= cfg_data[8 +: MATCH_RULES];
            end
            trace_pkg::REG_TRIG_DELAY: trig_delay <= cfg_data;
            trace_pkg::REG_TRIG_WIDTH: trig_width <= cfg_data;
            default: ;   // rule words handled below
         endcase
      end
   end

   // pattern and mask words, rules past MATCH_RULES fall through
   always_ff @(posedge trace_clk) begin
      for (int n = 0; n < MATCH_RULES; n++) begin
         if (rule_sel && int'(rule_off[AW-1:2]) == n) begin
            case (rule_off[1:0])
               2'd0: cfg.pattern[n][DW-1:0]    <= cfg_data;
               2'd1: cfg.pattern[n][2*DW-1:DW] <= cfg_data;
               2'd2: cfg.mask[n][DW-1:0]       <= cfg_data;
               2'd3: cfg.mask[n][2*DW-1:DW]    <= cfg_data;
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/trace_frontend.sv
// ================================================
// trace port front end
// nibble assembly, timestamp and raw byte records
// ================================================
`timescale 1ns/1ps
`default_nettype none

module trace_frontend (
   input  logic                                 trace_clk,
   input  logic                                 reset,
   input  logic [trace_pkg::TRACE_NIBBLE_W-1:0] trace_data,
   input  logic                                 arm,
   input  logic                                 capture_raw,
   output logic                                 byte_valid,
   output logic [trace_pkg::BYTE_W-1:0]         byte_data,
   output logic [trace_pkg::TIME_W-1:0]         timestamp,
   output logic                                 req,
   output trace_pkg::capture_record_t           record,
   input  logic                                 grant
);
   logic                                 high_phase;   // next nibble is the upper half
   logic [trace_pkg::TRACE_NIBBLE_W-1:0] low_nibble;
   logic                                 arm_q;
   logic                                 raw_new;
   logic                                 load;

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         high_phase <= 1'b0;
         byte_valid <= 1'b0;
      end else begin
         high_phase <= !high_phase;
         byte_valid <= high_phase;
      end
   end

   always_ff @(posedge trace_clk) begin
      if (!high_phase)
         low_nibble <= trace_data;
      else
         byte_data <= {trace_data, low_nibble};
   end

   // restarts at arm, then saturates
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         arm_q     <= 1'b0;
         timestamp <= '0;
      end else begin
         arm_q <= arm;
         if (arm && !arm_q)
            timestamp <= '0;
         else if (timestamp != '1)
            timestamp <= timestamp + 1'b1;
      end
   end

   assign raw_new = byte_valid && arm && capture_raw;
   assign load    = raw_new && (!req || grant);   // a held record blocks new ones

   always_ff @(posedge trace_clk) begin
      if (reset)
         req <= 1'b0;
      else if (load)
         req <= 1'b1;
      else if (grant)
         req <= 1'b0;
   end

   always_ff @(posedge trace_clk) begin
      if (load)
         record <= '{kind: trace_pkg::KIND_RAW, data: byte_data, timestamp: timestamp};
   end

endmodule

`default_nettype wire

//--- rtl/pattern_matcher.sv
// ================================================
// history window and masked rule compare
// issues match records and the trigger request
// ================================================
`timescale 1ns/1ps
`default_nettype none

module pattern_matcher #(
   parameter int MATCH_RULES = 4
) (
   input  logic                         trace_clk,
   input  logic                         reset,
   trace_cfg_if.matcher                 cfg,
   input  logic                         arm,
   input  logic                         byte_valid,
   input  logic [trace_pkg::BYTE_W-1:0] byte_data,
   input  logic [trace_pkg::TIME_W-1:0] timestamp,
   output logic                         req,
   output trace_pkg::capture_record_t   record,
   input  logic                         grant,
   output logic                         match_fire,
   output logic                         trig_hit
);
   localparam int BW    = trace_pkg::BYTE_W;
   localparam int WIN_W = trace_pkg::WINDOW_BYTES * BW;

   logic [WIN_W-1:0]       window;   // newest byte in 7:0
   logic                   eval;     // window just took a byte
   logic [MATCH_RULES-1:0] hits;
   logic                   fire;
   logic                   load;

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         window <= '0;
         eval   <= 1'b0;
      end else begin
         eval <= byte_valid;
         if (byte_valid)
            window <= {window[WIN_W-BW-1:0], byte_data};
      end
   end

   always_comb begin
      for (int r = 0; r < MATCH_RULES; r++) begin
         hits[r] = cfg.rule_enable[r] &&
                   ((window & cfg.mask[r]) == (cfg.pattern[r] & cfg.mask[r]));
      end
   end

   assign fire = eval && arm && (hits != '0);
   assign load = fire && (!req || grant);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         match_fire <= 1'b0;
         trig_hit   <= 1'b0;
      end else begin
         match_fire <= fire;
         trig_hit   <= fire && ((hits & cfg.trig_enable) != '0);
      end
   end

   // one pending match record
   always_ff @(posedge trace_clk) begin
      if (reset)
         req <= 1'b0;
      else if (load)
         req <= 1'b1;
      else if (grant)
         req <= 1'b0;
   end

   always_ff @(posedge trace_clk) begin
      if (load)
         record <= '{kind: trace_pkg::KIND_MATCH, data: BW'(hits), timestamp: timestamp};
   end

endmodule

`default_nettype wire

//--- rtl/trigger_pulser.sv
// ================================================
// trigger pulse generator
// programmable delay then a fixed-width pulse
// ================================================
`timescale 1ns/1ps
`default_nettype none

module trigger_pulser (
   input  logic                             trace_clk,
   input  logic                             reset,
   input  logic                             match_fire,
   input  logic                             trig_hit,
   input  logic [trace_pkg::CFG_DATA_W-1:0] trig_delay,
   input  logic [trace_pkg::CFG_DATA_W-1:0] trig_width,
   output logic                             trig_out
);
   typedef enum logic [1:0] {IDLE, DELAY, PULSE} state_t;

   state_t                           state;
   logic [trace_pkg::CFG_DATA_W-1:0] cnt;
   logic [trace_pkg::CFG_DATA_W-1:0] high_run;   // cycles trig_out has been high

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state <= IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            IDLE: if (match_fire && trig_hit && trig_width != '0) begin
               state <= (trig_delay == '0) ? PULSE : DELAY;
               cnt   <= (trig_delay == '0) ? trig_width - 1'b1 : trig_delay - 1'b1;
            end
            DELAY: if (cnt == '0) begin
               state <= PULSE;
               cnt   <= trig_width - 1'b1;
            end else
               cnt <= cnt - 1'b1;
            PULSE: if (cnt == '0)
               state <= IDLE;
            else
               cnt <= cnt - 1'b1;
            default: state <= IDLE;
         endcase
      end
   end

   assign trig_out = (state == PULSE);

   always_ff @(posedge trace_clk) begin
      if (reset)
         high_run <= '0;
      else
         high_run <= trig_out ? high_run + 1'b1 : '0;
   end

   a_pulse_width: assert property (@(posedge trace_clk) disable iff (reset)
      trig_out |-> high_run < trig_width);

endmodule

`default_nettype wire

//--- rtl/capture_arbiter.sv
// ================================================
// round-robin arbiter for the capture FIFO port
// pushes only while write credits remain
// ================================================
`timescale 1ns/1ps
`default_nettype none

module capture_arbiter #(
   parameter type record_t   = logic,
   parameter int  FIFO_DEPTH = 16
) (
   input  logic    trace_clk,
   input  logic    reset,
   input  logic    req_a,
   input  record_t record_a,
   input  logic    req_b,
   input  record_t record_b,
   input  logic    credit_return,
   output logic    grant_a,
   output logic    grant_b,
   output logic    push,
   output record_t push_record
);
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   logic [CW-1:0] credit;
   logic          last_a;   // a took the previous grant

   assign grant_a     = (credit != '0) && req_a && (!req_b || !last_a);
   assign grant_b     = (credit != '0) && req_b && !grant_a;
   assign push        = grant_a || grant_b;
   assign push_record = grant_a ? record_a : record_b;

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         credit <= CW'(FIFO_DEPTH);
         last_a <= 1'b0;
      end else begin
         credit <= credit - CW'(push) + CW'(credit_return);
         if (push)
            last_a <= grant_a;
      end
   end

   a_no_push_broke: assert property (@(posedge trace_clk) disable iff (reset)
      credit == '0 |-> !push);

   // FIFO must return no more credits than were spent
   a_credit_bound: assert property (@(posedge trace_clk) disable iff (reset)
      credit <= CW'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- rtl/capture_fifo.sv
// ================================================
// show-ahead capture record FIFO
// ================================================
`timescale 1ns/1ps
`default_nettype none

module capture_fifo #(
   parameter type record_t   = logic,
   parameter int  FIFO_DEPTH = 16
) (
   input  logic    trace_clk,
   input  logic    reset,
   input  logic    push,
   input  record_t push_record,
   input  logic    rd_en,
   output logic    rd_valid,
   output record_t rd_record,
   output logic    credit_return
);
   localparam int AW = $clog2(FIFO_DEPTH);
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   record_t       mem [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          pop;

   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
      return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign rd_valid      = (count != '0);
   assign rd_record     = mem[rd_ptr];   // head always on the output
   assign pop           = rd_en && rd_valid;
   assign credit_return = pop;

   always_ff @(posedge trace_clk) begin
      if (push)
         mem[wr_ptr] <= push_record;
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         count <= count + CW'(push) - CW'(pop);
      end
   end

   // the arbiter's credits keep this from overflowing
   a_no_overflow: assert property (@(posedge trace_clk) disable iff (reset)
      push |-> count < CW'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- rtl/trace_top.sv
// ================================================
// parallel trace sniffer top level
// ================================================
`timescale 1ns/1ps
`default_nettype none

module trace_top #(
   parameter int MATCH_RULES = 4,
   parameter int FIFO_DEPTH  = 16
) (
   input  logic                                 trace_clk,
   input  logic                                 reset,
   input  logic [trace_pkg::TRACE_NIBBLE_W-1:0] trace_data,
   input  logic                                 cfg_write,
   input  logic [trace_pkg::CFG_ADDR_W-1:0]     cfg_addr,
   input  logic [trace_pkg::CFG_DATA_W-1:0]     cfg_data,
   input  logic                                 rd_en,
   output logic                                 rd_valid,
   output logic [1:0]                           rd_kind,
   output logic [trace_pkg::BYTE_W-1:0]         rd_data,
   output logic [trace_pkg::TIME_W-1:0]         rd_time,
   output logic                                 trig_out,
   output logic                                 capturing
);
   logic                             arm;
   logic                             capture_raw;
   logic [trace_pkg::CFG_DATA_W-1:0] trig_delay;
   logic [trace_pkg::CFG_DATA_W-1:0] trig_width;
   logic                             byte_valid;
   logic [trace_pkg::BYTE_W-1:0]     byte_data;
   logic [trace_pkg::TIME_W-1:0]     timestamp;
   logic                             fe_req, fe_grant;
   logic                             pm_req, pm_grant;
   trace_pkg::capture_record_t       fe_record, pm_record;
   trace_pkg::capture_record_t       push_record, rd_record;
   logic                             push, credit_return;
   logic                             match_fire, trig_hit;

   trace_cfg_if #(.MATCH_RULES(MATCH_RULES)) cfg_bus ();

   trace_regs #(.MATCH_RULES(MATCH_RULES)) U_regs (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .cfg_write   (cfg_write),
      .cfg_addr    (cfg_addr),
      .cfg_data    (cfg_data),
      .cfg         (cfg_bus.regs),
      .arm         (arm),
      .capture_raw (capture_raw),
      .trig_delay  (trig_delay),
      .trig_width  (trig_width)
   );

   trace_frontend U_frontend (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .trace_data  (trace_data),
      .arm         (arm),
      .capture_raw (capture_raw),
      .byte_valid  (byte_valid),
      .byte_data   (byte_data),
      .timestamp   (timestamp),
      .req         (fe_req),
      .record      (fe_record),
      .grant       (fe_grant)
   );

   pattern_matcher #(.MATCH_RULES(MATCH_RULES)) U_matcher (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .cfg         (cfg_bus.matcher),
      .arm         (arm),
      .byte_valid  (byte_valid),
      .byte_data   (byte_data),
      .timestamp   (timestamp),
      .req         (pm_req),
      .record      (pm_record),
      .grant       (pm_grant),
      .match_fire  (match_fire),
      .trig_hit    (trig_hit)
   );

   trigger_pulser U_pulser (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .match_fire  (match_fire),
      .trig_hit    (trig_hit),
      .trig_delay  (trig_delay),
      .trig_width  (trig_width),
      .trig_out    (trig_out)
   );

   capture_arbiter #(
      .record_t    (trace_pkg::capture_record_t),
      .FIFO_DEPTH  (FIFO_DEPTH)
   ) U_arbiter (
      .trace_clk     (trace_clk),
      .reset         (reset),
      .req_a         (fe_req),
      .record_a      (fe_record),
      .req_b         (pm_req),
      .record_b      (pm_record),
      .credit_return (credit_return),
      .grant_a       (fe_grant),
      .grant_b       (pm_grant),
      .push          (push),
      .push_record   (push_record)
   );

   capture_fifo #(
      .record_t    (trace_pkg::capture_record_t),
      .FIFO_DEPTH  (FIFO_DEPTH)
   ) U_fifo (
      .trace_clk     (trace_clk),
      .reset         (reset),
      .push          (push),
      .push_record   (push_record),
      .rd_en         (rd_en),
      .rd_valid      (rd_valid),
      .rd_record     (rd_record),
      .credit_return (credit_return)
   );

   assign rd_kind   = rd_record.kind;
   assign rd_data   = rd_record.data;
   assign rd_time   = rd_record.timestamp;
   assign capturing = arm;

endmodule

`default_nettype wire

//--- verification/trace_tb.sv
// ==================================================
// trace sniffer testbench
// directed tests for capture, match, trigger and flow
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module trace_tb;

   localparam int CLK_PERIOD  = 40;
   localparam int FIFO_DEPTH  = 16;
   localparam int MATCH_RULES = 4;
   // reset plus the cycle budget of each test
   localparam int TEST_CYCLES = 10 + 60 + 100 + 100 + 80 + 160 + 100;

   localparam logic [63:0] PATTERN = 64'h0000_0000_0000_a53c;   // a5 then 3c
   localparam logic [63:0] MASK    = 64'h0000_0000_0000_ffff;

   logic                                 trace_clk;
   logic                                 reset;
   logic [trace_pkg::TRACE_NIBBLE_W-1:0] trace_data;
   logic                                 cfg_write;
   logic [trace_pkg::CFG_ADDR_W-1:0]     cfg_addr;
   logic [trace_pkg::CFG_DATA_W-1:0]     cfg_data;
   logic                                 rd_en;
   logic                                 rd_valid;
   logic [1:0]                           rd_kind;
   logic [trace_pkg::BYTE_W-1:0]         rd_data;
   logic [trace_pkg::TIME_W-1:0]         rd_time;
   logic                                 trig_out;
   logic                                 capturing;

   int                         errors = 0;
   int                         checks = 0;
   integer                     seed;
   trace_pkg::capture_record_t rec_q[$];    // records popped by the reader
   logic [7:0]                 sent_q[$];
   int                         trig_cycles  = 0;
   int                         trig_pulses  = 0;
   int                         trig_run     = 0;
   int                         trig_max_run = 0;

   trace_top #(.MATCH_RULES(MATCH_RULES), .FIFO_DEPTH(FIFO_DEPTH)) dut (
      .trace_clk  (trace_clk),
      .reset      (reset),
      .trace_data (trace_data),
      .cfg_write  (cfg_write),
      .cfg_addr   (cfg_addr),
      .cfg_data   (cfg_data),
      .rd_en      (rd_en),
      .rd_valid   (rd_valid),
      .rd_kind    (rd_kind),
      .rd_data    (rd_data),
      .rd_time    (rd_time),
      .trig_out   (trig_out),
      .capturing  (capturing)
   );

   initial begin
      trace_clk = 1'b0;
      forever #(CLK_PERIOD / 2) trace_clk = ~trace_clk;
   end

   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      $display("timeout: tests still running after %0d clock cycles", 2 * TEST_CYCLES);
      $display("Errors found");
      $finish;
   end

   // a pop happens on the next rising edge
   always @(negedge trace_clk) begin
      if (!reset && rd_en && rd_valid)
         rec_q.push_back('{kind: trace_pkg::record_kind_t'(rd_kind), data: rd_data,
                           timestamp: rd_time});
   end

   always @(negedge trace_clk) begin
      if (trig_out) begin
         trig_cycles++;
         trig_run++;
         if (trig_run == 1)
            trig_pulses++;
         if (trig_run > trig_max_run)
            trig_max_run = trig_run;
      end else
         trig_run = 0;
   end

   task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
      end
   endtask

   // one byte period, low nibble first
   task automatic send_byte(input logic [7:0] b);
      trace_data = b[3:0];
      @(posedge trace_clk);
      #2;
      trace_data = b[7:4];
      @(posedge trace_clk);
      #2;
   endtask

   // register write during a byte period, the write applies to that period's byte
   task automatic write_reg(input logic [trace_pkg::CFG_ADDR_W-1:0] addr,
                            input logic [31:0] data, input logic [7:0] carried);
      cfg_write  = 1'b1;
      cfg_addr   = addr;
      cfg_data   = data;
      trace_data = carried[3:0];
      @(posedge trace_clk);
      #2;
      cfg_write  = 1'b0;
      trace_data = carried[7:4];
      @(posedge trace_clk);
      #2;
   endtask

   task automatic program_rule(input int n, input logic [63:0] pattern,
                               input logic [63:0] mask);
      logic [trace_pkg::CFG_ADDR_W-1:0] base;
      base = 6'(int'(trace_pkg::REG_RULE_BASE) + 4 * n);
      write_reg(base, pattern[31:0], 8'h00);
      write_reg(base + 6'd1, pattern[63:32], 8'h00);
      write_reg(base + 6'd2, mask[31:0], 8'h00);
      write_reg(base + 6'd3, mask[63:32], 8'h00);
   endtask

   // read until the FIFO stays empty for a few byte periods
   task automatic drain_records();
      int quiet;
      int periods;
      quiet   = 0;
      periods = 0;
      rd_en   = 1'b1;
      while (quiet < 4 && periods < 64) begin
         send_byte(8'h00);
         periods++;
         if (rd_valid)
            quiet = 0;
         else
            quiet++;
      end
      rd_en = 1'b0;
      if (quiet < 4) begin
         errors++;
         $display("drain did not finish, FIFO still busy after %0d byte periods", periods);
      end
   endtask

   task automatic send_pattern_stream(input logic [31:0] ctrl);
      write_reg(trace_pkg::REG_CONTROL, ctrl, 8'h11);
      send_byte(8'h22);
      send_byte(8'ha5);
      send_byte(8'h3c);
      send_byte(8'h44);
      send_byte(8'h55);
      write_reg(trace_pkg::REG_CONTROL, 32'h0, 8'h00);
   endtask

   task automatic raw_capture();
      logic [7:0] b;
      rec_q.delete();
      sent_q.delete();
      write_reg(trace_pkg::REG_RULE_ENABLE, 32'h0, 8'h00);
      rd_en = 1'b1;
      b = 8'($random(seed));
      sent_q.push_back(b);
      write_reg(trace_pkg::REG_CONTROL, 32'h3, b);   // arm and raw capture
      check_eq(32'(capturing), 32'd1, "capturing after arm");
      repeat (9) begin
         b = 8'($random(seed));
         sent_q.push_back(b);
         send_byte(b);
      end
      write_reg(trace_pkg::REG_CONTROL, 32'h0, 8'h00);
      drain_records();
      check_eq(32'(rec_q.size()), 32'd10, "raw record count");
      for (int i = 0; i < rec_q.size() && i < sent_q.size(); i++) begin
         check_eq(32'(rec_q[i].kind), 32'(trace_pkg::KIND_RAW), "raw record kind");
         check_eq(32'(rec_q[i].data), 32'(sent_q[i]), "raw record data");
         if (i > 0)
            check_eq(32'(rec_q[i].timestamp - rec_q[i-1].timestamp), 32'd2, "raw time step");
      end
   endtask

   task automatic pattern_match();
      rec_q.delete();
      program_rule(2, PATTERN, MASK);
      write_reg(trace_pkg::REG_RULE_ENABLE, 32'h4, 8'h00);
      rd_en = 1'b1;
      send_pattern_stream(32'h1);
      drain_records();
      check_eq(32'(rec_q.size()), 32'd1, "match record count, rule 2 enabled");
      if (rec_q.size() == 1) begin
         check_eq(32'(rec_q[0].kind), 32'(trace_pkg::KIND_MATCH), "match record kind");
         check_eq(32'(rec_q[0].data), 32'h04, "match bitmap");
      end
      rec_q.delete();
      write_reg(trace_pkg::REG_RULE_ENABLE, 32'h0, 8'h00);
      rd_en = 1'b1;
      send_pattern_stream(32'h1);
      drain_records();
      check_eq(32'(rec_q.size()), 32'd0, "match record count, rule 2 disabled");
   endtask

   task automatic trigger_pulse();
      int waited;
      rec_q.delete();
      trig_cycles  = 0;
      trig_pulses  = 0;
      trig_max_run = 0;
      write_reg(trace_pkg::REG_TRIG_DELAY, 32'd5, 8'h00);
      write_reg(trace_pkg::REG_TRIG_WIDTH, 32'd3, 8'h00);
      write_reg(trace_pkg::REG_RULE_ENABLE, 32'h0404, 8'h00);   // rule 2 with trigger
      rd_en = 1'b1;
      send_pattern_stream(32'h1);
      waited = 0;
      while ((trig_pulses == 0 || trig_out) && waited < 20) begin
         send_byte(8'h00);
         waited++;
      end
      if (trig_pulses == 0 || trig_out) begin
         errors++;
         $display("trigger pulse did not appear or did not end in time");
      end
      repeat (8) send_byte(8'h00);   // watch for a second pulse
      check_eq(trig_pulses, 32'd1, "trigger pulse count");
      check_eq(trig_max_run, 32'd3, "trigger pulse width");
      check_eq(trig_cycles, 32'd3, "trigger high cycles");
      drain_records();
      check_eq(32'(rec_q.size()), 32'd1, "match record count, trigger test");
   endtask

   task automatic disarmed_capture();
      rec_q.delete();
      trig_cycles = 0;
      write_reg(trace_pkg::REG_RULE_ENABLE, 32'h0404, 8'h00);
      rd_en = 1'b1;
      send_pattern_stream(32'h2);   // raw capture set, arm clear
      write_reg(trace_pkg::REG_CONTROL, 32'h2, 8'h00);
      check_eq(32'(capturing), 32'd0, "capturing while disarmed");
      repeat (10) send_byte(8'($random(seed)));
      write_reg(trace_pkg::REG_CONTROL, 32'h0, 8'h00);
      drain_records();
      check_eq(32'(rec_q.size()), 32'd0, "record count while disarmed");
      check_eq(trig_cycles, 32'd0, "trigger high cycles while disarmed");
   endtask

   task automatic back_pressure();
      logic [7:0] b;
      int         next;
      int         found;
      rec_q.delete();
      sent_q.delete();
      write_reg(trace_pkg::REG_RULE_ENABLE, 32'h0, 8'h00);
      rd_en = 1'b0;
      b = 8'($random(seed));
      sent_q.push_back(b);
      write_reg(trace_pkg::REG_CONTROL, 32'h3, b);
      repeat (39) begin
         b = 8'($random(seed));
         sent_q.push_back(b);
         send_byte(b);
      end
      rd_en = 1'b1;   // reader resumes while capture goes on
      repeat (10) begin
         b = 8'($random(seed));
         sent_q.push_back(b);
         send_byte(b);
      end
      write_reg(trace_pkg::REG_CONTROL, 32'h0, 8'h00);
      drain_records();
      // FIFO_DEPTH stored plus one held in the front end
      check_eq(32'(rec_q.size() >= FIFO_DEPTH + 1), 32'd1, "record count after stall");
      check_eq(32'(rec_q.size() > FIFO_DEPTH + 1), 32'd1, "records after the reader resumed");
      for (int i = 0; i < rec_q.size() && i <= FIFO_DEPTH; i++)
         check_eq(32'(rec_q[i].data), 32'(sent_q[i]), "record data before the stall");
      next = FIFO_DEPTH + 1;
      for (int i = FIFO_DEPTH + 1; i < rec_q.size(); i++) begin
         found = 0;
         while (next < sent_q.size() && found == 0) begin
            if (sent_q[next] == rec_q[i].data)
               found = 1;
            next++;
         end
         check_eq(found, 32'd1, "late record matches a later byte");
      end
   endtask

   task automatic mixed_traffic();
      logic [7:0] b;
      int         raw_n;
      int         match_n;
      rec_q.delete();
      write_reg(trace_pkg::REG_RULE_ENABLE, 32'h4, 8'h00);
      rd_en = 1'b1;
      b = 8'($random(seed));
      write_reg(trace_pkg::REG_CONTROL, 32'h3, b);
      repeat (5) send_byte(8'($random(seed)));
      send_byte(8'ha5);
      send_byte(8'h3c);
      repeat (5) send_byte(8'($random(seed)));
      write_reg(trace_pkg::REG_CONTROL, 32'h0, 8'h00);
      drain_records();
      raw_n   = 0;
      match_n = 0;
      for (int i = 0; i < rec_q.size(); i++) begin
         if (rec_q[i].kind == trace_pkg::KIND_RAW)
            raw_n++;
         else if (rec_q[i].kind == trace_pkg::KIND_MATCH)
            match_n++;
         if (i > 0)
            check_eq(32'(rec_q[i].timestamp >= rec_q[i-1].timestamp), 32'd1,
                     "timestamps in order");
      end
      check_eq(raw_n, 32'd13, "raw records in mixed traffic");
      check_eq(32'(match_n >= 1), 32'd1, "match records in mixed traffic");
   endtask

   initial begin
      seed       = 32'h894570ca;
      reset      = 1'b1;
      trace_data = '0;
      cfg_write  = 1'b0;
      cfg_addr   = '0;
      cfg_data   = '0;
      rd_en      = 1'b0;
      repeat (8) @(posedge trace_clk);
      #2;
      reset = 1'b0;   // next edge samples a low nibble
      check_eq(32'(rd_valid), 32'd0, "rd_valid after reset");
      check_eq(32'(trig_out), 32'd0, "trig_out after reset");
      check_eq(32'(capturing), 32'd0, "capturing after reset");
      raw_capture();
      pattern_match();
      trigger_pulse();
      disarmed_capture();
      back_pressure();
      mixed_traffic();
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
rtl/trace_pkg.sv
rtl/trace_cfg_if.sv
rtl/trace_regs.sv
rtl/trace_frontend.sv
rtl/pattern_matcher.sv
rtl/trigger_pulser.sv
rtl/capture_arbiter.sv
rtl/capture_fifo.sv
rtl/trace_top.sv
verification/trace_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= trace_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard rtl/*.sv) $(wildcard verification/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "No errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
